/* mem_subsys_pkg.sv */
// memory subsystem package: geometry, request and response structs, cache controller state
`default_nettype none

package mem_subsys_pkg;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // geometry
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    localparam int ADDR_W = 32;                        // core address width.
    localparam int MEM_AW = 19;                        // 512 KB of memory.
    localparam int LINES  = 16;                        // lines per cache.
    localparam int IDX_W  = $clog2(LINES);             // index at bits [5:2].
    localparam int TAG_W  = MEM_AW - IDX_W - 2;        // tag at bits [18:6].

    // data window select bits, checked in this order
    localparam int DCACHE_BIT   = 30;
    localparam int TIMER_BIT    = 28;
    localparam int UNCACHED_BIT = 29;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // request and response bundles
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~

    // core data request, zero strobes is a read.
    typedef struct packed {
        logic              sel;
        logic [ADDR_W-1:0] addr;
        logic [31:0]       wdata;
        logic [3:0]        wstrb;
    } data_req_t;

    // one requester's view of the memory port.
    typedef struct packed {
        logic              valid;
        logic [MEM_AW-1:0] addr;
        logic [31:0]       wdata;
        logic [3:0]        wstrb;
    } mem_req_t;

    typedef struct packed {
        logic        ready;
        logic [31:0] rdata;
    } mem_rsp_t;

    // cache controller state.
    typedef enum logic [1:0] {
        IDLE,
        FILL,
        WRITE
    } fill_state_e;

endpackage

`default_nettype wire

/* cycle_timer.sv */
// cycle timer: free-running 32-bit counter of clock edges since reset
`timescale 1ns/1ps
`default_nettype none

module cycle_timer (
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    output logic [31:0]      count_o
);

    logic [31:0] count_q;

    // wraps at 2^32.
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            count_q <= '0;
        end else begin
            count_q <= count_q + 32'd1;
        end
    end

    assign count_o = count_q;

endmodule

`default_nettype wire

/* icache.sv */
// instruction cache: direct-mapped, read-only, refills one word per miss through the arbiter
`timescale 1ns/1ps
`default_nettype none

module icache
    import mem_subsys_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic [ADDR_W-1:0] fetch_addr_i,
    output logic [31:0]            fetch_data_o,
    output logic                   fetch_stall_o,
    output mem_req_t               mem_req_o,
    input  wire mem_rsp_t          mem_rsp_i
);

    logic [TAG_W-1:0]  tag_q [LINES];
    logic [31:0]       data_q [LINES];
    logic [LINES-1:0]  valid_q;
    fill_state_e       state_q;
    logic [MEM_AW-1:2] fill_addr_q;

    logic [IDX_W-1:0]  idx;
    logic [IDX_W-1:0]  fill_idx;
    logic [TAG_W-1:0]  tag;
    logic              hit;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign idx      = fetch_addr_i[IDX_W+1:2];
    assign tag      = fetch_addr_i[MEM_AW-1:IDX_W+2];
    assign hit      = valid_q[idx] && (tag_q[idx] == tag);
    assign fill_idx = fill_addr_q[IDX_W+1:2];

    assign fetch_data_o  = data_q[idx];
    assign fetch_stall_o = !hit || (state_q != IDLE);  // drops the cycle after refill.

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // refill control
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (!hit) begin
                        state_q <= FILL;
                    end
                end
                FILL: begin
                    if (mem_rsp_i.ready) begin
                        state_q           <= IDLE;
                        valid_q[fill_idx] <= 1'b1;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            fill_addr_q <= fetch_addr_i[MEM_AW-1:2];  // held for the whole refill.
        end
        if ((state_q == FILL) && mem_rsp_i.ready) begin
            tag_q[fill_idx]  <= fill_addr_q[MEM_AW-1:IDX_W+2];
            data_q[fill_idx] <= mem_rsp_i.rdata;
        end
    end

    always_comb begin
        mem_req_o       = '0;
        mem_req_o.valid = (state_q == FILL);
        mem_req_o.addr  = {fill_addr_q, 2'b00};
    end

endmodule

`default_nettype wire

/* dcache.sv */
// data cache: direct-mapped, write-through, no allocate on write miss, strobed write hits
`timescale 1ns/1ps
`default_nettype none

module dcache
    import mem_subsys_pkg::*;
(
    input  wire logic        clk_i,
    input  wire logic        rst_n_i,
    input  wire data_req_t   req_i,
    output logic [31:0]      rdata_o,
    output logic             stall_o,
    output mem_req_t         mem_req_o,
    input  wire mem_rsp_t    mem_rsp_i
);

    logic [TAG_W-1:0]  tag_q [LINES];
    logic [31:0]       data_q [LINES];
    logic [LINES-1:0]  valid_q;
    fill_state_e       state_q;
    data_req_t         pend_q;

    logic [ADDR_W-1:0] lk_addr;
    logic [IDX_W-1:0]  idx;
    logic [TAG_W-1:0]  tag;
    logic              hit;
    logic              is_wr;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // lookup
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    assign lk_addr = (state_q == IDLE) ? req_i.addr : pend_q.addr;
    assign idx     = lk_addr[IDX_W+1:2];
    assign tag     = lk_addr[MEM_AW-1:IDX_W+2];
    assign hit     = valid_q[idx] && (tag_q[idx] == tag);
    assign is_wr   = (req_i.wstrb != 4'b0000);

    assign rdata_o = data_q[idx];

    always_comb begin
        case (state_q)
            IDLE:    stall_o = req_i.sel && (is_wr || !hit);
            WRITE:   stall_o = !mem_rsp_i.ready;  // write completes on ready.
            default: stall_o = 1'b1;              // refill, release next cycle.
        endcase
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // controller
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            state_q <= IDLE;
            valid_q <= '0;
        end else begin
            case (state_q)
                IDLE: begin
                    if (req_i.sel && is_wr) begin
                        state_q <= WRITE;
                    end else if (req_i.sel && !hit) begin
                        state_q <= FILL;
                    end
                end
                FILL: begin
                    if (mem_rsp_i.ready) begin
                        state_q      <= IDLE;
                        valid_q[idx] <= 1'b1;
                    end
                end
                WRITE: begin
                    if (mem_rsp_i.ready) begin
                        state_q <= IDLE;
                    end
                end
                default: state_q <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (state_q == IDLE) begin
            pend_q <= req_i;
        end
        if ((state_q == FILL) && mem_rsp_i.ready) begin
            tag_q[idx]  <= tag;
            data_q[idx] <= mem_rsp_i.rdata;
        end
        // write hit merges the enabled bytes; a miss leaves the line alone.
        if ((state_q == WRITE) && mem_rsp_i.ready && hit) begin
            for (int b = 0; b < 4; b++) begin
                if (pend_q.wstrb[b]) begin
                    data_q[idx][8*b +: 8] <= pend_q.wdata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        mem_req_o       = '0;
        mem_req_o.valid = (state_q != IDLE);
        mem_req_o.addr  = {pend_q.addr[MEM_AW-1:2], 2'b00};
        mem_req_o.wdata = pend_q.wdata;
        mem_req_o.wstrb = pend_q.wstrb;  // zero on a refill.
    end

endmodule

`default_nettype wire

/* data_router.sv */
// data router: splits core data accesses into cached, uncached and timer windows
`timescale 1ns/1ps
`default_nettype none

module data_router
    import mem_subsys_pkg::*;
(
    input  wire data_req_t    data_req_i,
    output logic [31:0]       data_rdata_o,
    output logic              data_stall_o,
    output data_req_t         dc_req_o,
    input  wire logic [31:0]  dc_rdata_i,
    input  wire logic         dc_stall_i,
    output mem_req_t          uc_req_o,
    input  wire mem_rsp_t     uc_rsp_i,
    input  wire logic [31:0]  tmr_rdata_i
);

    logic win_dc;
    logic win_tmr;
    logic win_uc;

    // cached window wins, then timer, then uncached.
    assign win_dc  = data_req_i.addr[DCACHE_BIT];
    assign win_tmr = !win_dc && data_req_i.addr[TIMER_BIT];
    assign win_uc  = !win_dc && !data_req_i.addr[TIMER_BIT] && data_req_i.addr[UNCACHED_BIT];

    always_comb begin
        dc_req_o     = data_req_i;
        dc_req_o.sel = data_req_i.sel && win_dc;
    end

    // uncached accesses go straight to the arbiter.
    always_comb begin
        uc_req_o.valid = data_req_i.sel && win_uc;
        uc_req_o.addr  = data_req_i.addr[MEM_AW-1:0];
        uc_req_o.wdata = data_req_i.wdata;
        uc_req_o.wstrb = data_req_i.wstrb;
    end

    always_comb begin
        data_rdata_o = '0;  // unmapped reads return zero.
        data_stall_o = 1'b0;
        if (win_dc) begin
            data_rdata_o = dc_rdata_i;
            data_stall_o = dc_stall_i;
        end else if (win_tmr) begin
            data_rdata_o = tmr_rdata_i;
        end else if (win_uc) begin
            data_rdata_o = uc_rsp_i.rdata;
            data_stall_o = data_req_i.sel && !uc_rsp_i.ready;
        end
    end

endmodule

`default_nettype wire

/* mem_arbiter.sv */
// memory arbiter: fixed priority dcache, uncached, icache, grant held until ready
`timescale 1ns/1ps
`default_nettype none

module mem_arbiter
    import mem_subsys_pkg::*;
(
    input  wire logic      clk_i,
    input  wire logic      rst_n_i,
    input  wire mem_req_t  dc_req_i,
    output mem_rsp_t       dc_rsp_o,
    input  wire mem_req_t  uc_req_i,
    output mem_rsp_t       uc_rsp_o,
    input  wire mem_req_t  ic_req_i,
    output mem_rsp_t       ic_rsp_o,
    output mem_req_t       mem_req_o,
    input  wire mem_rsp_t  mem_rsp_i
);

    // one-hot grants. bit 0 dcache, bit 1 uncached, bit 2 icache.
    logic [2:0] gnt_q;
    logic [2:0] gnt_new;
    logic [2:0] gnt;

    always_comb begin
        gnt_new = 3'b000;
        if (dc_req_i.valid) begin
            gnt_new = 3'b001;
        end else if (uc_req_i.valid) begin
            gnt_new = 3'b010;
        end else if (ic_req_i.valid) begin
            gnt_new = 3'b100;
        end
    end

    // a held grant keeps the port until its ready.
    assign gnt = (gnt_q != 3'b000) ? gnt_q : gnt_new;

    always_ff @(posedge clk_i) begin
        if (!rst_n_i) begin
            gnt_q <= 3'b000;
        end else if (mem_rsp_i.ready) begin
            gnt_q <= 3'b000;
        end else if (gnt_q == 3'b000) begin
            gnt_q <= gnt_new;
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // port mux
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    always_comb begin
        mem_req_o = '0;  // valid low when nobody is granted.
        if (gnt[0]) begin
            mem_req_o = dc_req_i;
        end else if (gnt[1]) begin
            mem_req_o = uc_req_i;
        end else if (gnt[2]) begin
            mem_req_o = ic_req_i;
        end
    end

    always_comb begin
        dc_rsp_o.rdata = mem_rsp_i.rdata;
        uc_rsp_o.rdata = mem_rsp_i.rdata;
        ic_rsp_o.rdata = mem_rsp_i.rdata;
        dc_rsp_o.ready = gnt[0] && mem_rsp_i.ready;
        uc_rsp_o.ready = gnt[1] && mem_rsp_i.ready;
        ic_rsp_o.ready = gnt[2] && mem_rsp_i.ready;
    end

endmodule

`default_nettype wire

/* mem_subsys_top.sv */
// memory subsystem top: caches, data router, cycle timer and memory arbiter
`timescale 1ns/1ps
`default_nettype none

module mem_subsys_top
    import mem_subsys_pkg::*;
(
    input  wire logic              clk_i,
    input  wire logic              rst_n_i,
    input  wire logic [ADDR_W-1:0] ifetch_addr_i,
    output logic [31:0]            ifetch_data_o,
    output logic                   ifetch_stall_o,
    input  wire data_req_t         data_req_i,
    output logic [31:0]            data_rdata_o,
    output logic                   data_stall_o,
    output mem_req_t               mem_req_o,
    input  wire mem_rsp_t          mem_rsp_i
);

    data_req_t   dc_req;
    logic [31:0] dc_rdata;
    logic        dc_stall;
    logic [31:0] tmr_count;

    mem_req_t    ic_mem_req;
    mem_req_t    dc_mem_req;
    mem_req_t    uc_mem_req;
    mem_rsp_t    ic_mem_rsp;
    mem_rsp_t    dc_mem_rsp;
    mem_rsp_t    uc_mem_rsp;

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // fetch side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    icache i_icache (
        .clk_i         (clk_i),
        .rst_n_i       (rst_n_i),
        .fetch_addr_i  (ifetch_addr_i),
        .fetch_data_o  (ifetch_data_o),
        .fetch_stall_o (ifetch_stall_o),
        .mem_req_o     (ic_mem_req),
        .mem_rsp_i     (ic_mem_rsp)
    );

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // data side
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    data_router i_data_router (
        .data_req_i   (data_req_i),
        .data_rdata_o (data_rdata_o),
        .data_stall_o (data_stall_o),
        .dc_req_o     (dc_req),
        .dc_rdata_i   (dc_rdata),
        .dc_stall_i   (dc_stall),
        .uc_req_o     (uc_mem_req),
        .uc_rsp_i     (uc_mem_rsp),
        .tmr_rdata_i  (tmr_count)
    );

    dcache i_dcache (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .req_i     (dc_req),
        .rdata_o   (dc_rdata),
        .stall_o   (dc_stall),
        .mem_req_o (dc_mem_req),
        .mem_rsp_i (dc_mem_rsp)
    );

    cycle_timer i_cycle_timer (
        .clk_i   (clk_i),
        .rst_n_i (rst_n_i),
        .count_o (tmr_count)
    );

    mem_arbiter i_mem_arbiter (
        .clk_i     (clk_i),
        .rst_n_i   (rst_n_i),
        .dc_req_i  (dc_mem_req),
        .dc_rsp_o  (dc_mem_rsp),
        .uc_req_i  (uc_mem_req),
        .uc_rsp_o  (uc_mem_rsp),
        .ic_req_i  (ic_mem_req),
        .ic_rsp_o  (ic_mem_rsp),
        .mem_req_o (mem_req_o),
        .mem_rsp_i (mem_rsp_i)
    );

endmodule

`default_nettype wire

/* tb_mem_subsys.sv */
// memory subsystem testbench: memory model, random core traffic and a reference cache model
`timescale 1ns/1ps
`default_nettype none

module tb_mem_subsys
    import mem_subsys_pkg::*;
();

    localparam int     WORDS   = 1 << (MEM_AW - 2);
    localparam int     TIMEOUT = 200;
    localparam longint PERIOD  = 100;

    logic        clk_i;
    logic        rst_n_i;
    logic [31:0] ifetch_addr_i;
    logic [31:0] ifetch_data_o;
    logic        ifetch_stall_o;
    data_req_t   data_req_i;
    logic [31:0] data_rdata_o;
    logic        data_stall_o;
    mem_req_t    mem_req_o;
    mem_rsp_t    mem_rsp_i;

    logic [31:0] mem [WORDS];       // backing store seen by the DUT.
    logic [31:0] ref_mem [WORDS];   // expected memory contents.
    logic [12:0] dc_tag [LINES];
    logic        dc_valid [LINES];
    logic [31:0] dc_data [LINES];
    logic [12:0] ic_tag [LINES];
    logic        ic_valid [LINES];
    logic [31:0] ic_data [LINES];

    logic [MEM_AW-1:0] xfer_log [$];  // order of transfers on the port.
    int                min_dly;
    int                max_dly;
    int                errors;
    int                bad_tests;
    longint            last_low_t;

    mem_subsys_top i_dut (
        .clk_i          (clk_i),
        .rst_n_i        (rst_n_i),
        .ifetch_addr_i  (ifetch_addr_i),
        .ifetch_data_o  (ifetch_data_o),
        .ifetch_stall_o (ifetch_stall_o),
        .data_req_i     (data_req_i),
        .data_rdata_o   (data_rdata_o),
        .data_stall_o   (data_stall_o),
        .mem_req_o      (mem_req_o),
        .mem_rsp_i      (mem_rsp_i)
    );

    initial begin : clock_gen
        clk_i = 1'b0;
        forever begin
            #(PERIOD / 2) clk_i = ~clk_i;
        end
    end

    function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] wdata,
                                                input logic [3:0] wstrb);
        logic [31:0] res;
        res = old;
        for (int b = 0; b < 4; b++) begin
            if (wstrb[b]) begin
                res[8*b +: 8] = wdata[8*b +: 8];
            end
        end
        return res;
    endfunction

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // memory model
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : memory_model
        mem_req_t req_s;
        logic     done;
        logic     busy;
        int       left;
        mem_rsp_i = '0;
        busy      = 1'b0;
        left      = 0;
        forever begin
            @(posedge clk_i);
            req_s = mem_req_o;                      // sampled before the edge updates.
            done  = req_s.valid && mem_rsp_i.ready;
            @(negedge clk_i);
            if (done) begin
                mem_rsp_i.ready = 1'b0;
                busy            = 1'b0;
            end else if (req_s.valid) begin
                if (!busy) begin
                    busy = 1'b1;
                    left = min_dly + int'($urandom % (max_dly - min_dly + 1));
                end
                if (left == 0) begin
                    mem_rsp_i.ready = 1'b1;
                    mem_rsp_i.rdata = mem[req_s.addr[MEM_AW-1:2]];
                    mem[req_s.addr[MEM_AW-1:2]] = merge_bytes(mem[req_s.addr[MEM_AW-1:2]],
                                                              req_s.wdata, req_s.wstrb);
                    xfer_log.push_back(req_s.addr);
                end else begin
                    left--;
                end
            end
        end
    end

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // reference model and core-side tasks
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    task automatic model_dc_read(input logic [31:0] addr, output logic [31:0] exp,
                                 output logic hit);
        logic [3:0] i;
        i   = addr[5:2];
        hit = dc_valid[i] && (dc_tag[i] == addr[18:6]);
        if (!hit) begin
            dc_valid[i] = 1'b1;
            dc_tag[i]   = addr[18:6];
            dc_data[i]  = ref_mem[addr[18:2]];
        end
        exp = dc_data[i];
    endtask

    // write through, line touched only on a hit.
    task automatic model_dc_write(input logic [31:0] addr, input logic [31:0] wdata,
                                  input logic [3:0] wstrb);
        logic [3:0] i;
        i = addr[5:2];
        ref_mem[addr[18:2]] = merge_bytes(ref_mem[addr[18:2]], wdata, wstrb);
        if (dc_valid[i] && (dc_tag[i] == addr[18:6])) begin
            dc_data[i] = merge_bytes(dc_data[i], wdata, wstrb);
        end
    endtask

    task automatic model_ic_fetch(input logic [31:0] addr, output logic [31:0] exp,
                                  output logic hit);
        logic [3:0] i;
        i   = addr[5:2];
        hit = ic_valid[i] && (ic_tag[i] == addr[18:6]);
        if (!hit) begin
            ic_valid[i] = 1'b1;
            ic_tag[i]   = addr[18:6];
            ic_data[i]  = ref_mem[addr[18:2]];
        end
        exp = ic_data[i];
    endtask

    task automatic backdoor_write(input logic [31:0] addr, input logic [31:0] value);
        mem[addr[18:2]]     = value;
        ref_mem[addr[18:2]] = value;
    endtask

    task automatic data_access(input logic [31:0] addr, input logic [31:0] wdata,
                               input logic [3:0] wstrb, output logic [31:0] rdata,
                               output int cycles, output longint t_done);
        logic stalled;
        @(negedge clk_i);
        data_req_i.sel   = 1'b1;
        data_req_i.addr  = addr;
        data_req_i.wdata = wdata;
        data_req_i.wstrb = wstrb;
        cycles = 0;
        do begin
            @(posedge clk_i);
            cycles++;
            stalled = data_stall_o;
            rdata   = data_rdata_o;
            t_done  = $time;
        end while (stalled && cycles < TIMEOUT);
        if (stalled) begin
            $display("data access to %h still stalled after %0d cycles", addr, TIMEOUT);
            errors++;
        end
        @(negedge clk_i);
        data_req_i.sel = 1'b0;
    endtask

    task automatic fetch(input logic [31:0] addr, output logic [31:0] data, output int cycles);
        logic stalled;
        @(negedge clk_i);
        ifetch_addr_i = addr;
        cycles = 0;
        do begin
            @(posedge clk_i);
            cycles++;
            stalled = ifetch_stall_o;
            data    = ifetch_data_o;
        end while (stalled && cycles < TIMEOUT);
        if (stalled) begin
            $display("fetch of %h still stalled after %0d cycles", addr, TIMEOUT);
            errors++;
        end
    endtask

    task automatic end_test(input string name, input int err_before);
        if (errors == err_before) begin
            $display("test %-26s ok", name);
        end else begin
            bad_tests++;
            $display("test %-26s %0d errors", name, errors - err_before);
        end
    endtask

    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    // test sequence
    // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
    initial begin : stimulus
        logic [31:0] addr;
        logic [31:0] daddr;
        logic [31:0] wdata;
        logic [31:0] got;
        logic [31:0] got_i;
        logic [31:0] exp;
        logic [31:0] exp_i;
        logic [31:0] first;
        logic [3:0]  strb;
        logic        hit;
        logic        ic_done;
        logic        dc_done;
        int          cycles;
        int          err0;
        int          k;
        int          log_base;
        longint      t1;
        longint      t2;
        void'($urandom(32'hac4ad2f4));
        errors        = 0;
        bad_tests     = 0;
        min_dly       = 0;
        max_dly       = 4;
        rst_n_i       = 1'b0;
        ifetch_addr_i = '0;
        data_req_i    = '0;
        for (int w = 0; w < WORDS; w++) begin
            mem[w]     = 32'(w) * 32'h9e37_79b9 + 32'h1357_9bdf;  // odd multiplier, unique words.
            ref_mem[w] = mem[w];
        end
        for (int i = 0; i < LINES; i++) begin
            dc_valid[i] = 1'b0;
            ic_valid[i] = 1'b0;
        end
        repeat (10) @(posedge clk_i);
        last_low_t = $time;  // last edge that sees reset low.
        @(negedge clk_i);
        rst_n_i = 1'b1;

        err0 = errors;
        for (int n = 0; n < 120; n++) begin
            addr = ($urandom % 48) << 2;
            model_ic_fetch(addr, exp, hit);
            fetch(addr, got, cycles);
            if (got !== exp) begin
                $display("Fail at %0t: ifetch_data_o got %h expected %h", $time, got, exp);
                errors++;
            end
            if (hit && cycles != 1) begin
                $display("fetch hit at %h took %0d cycles instead of one", addr, cycles);
                errors++;
            end
        end
        end_test("random fetches", err0);

        err0 = errors;
        for (int n = 0; n < 200; n++) begin
            addr = 32'h4004_0000 | (($urandom % 64) << 2);
            if ($urandom % 2 == 1) begin
                wdata = $urandom;
                strb  = 4'($urandom % 15 + 1);
                model_dc_write(addr, wdata, strb);
                data_access(addr, wdata, strb, got, cycles, t1);
                if (mem[addr[18:2]] !== ref_mem[addr[18:2]]) begin
                    $display("Fail at %0t: memory word got %h expected %h", $time,
                             mem[addr[18:2]], ref_mem[addr[18:2]]);
                    errors++;
                end
            end else begin
                model_dc_read(addr, exp, hit);
                data_access(addr, '0, 4'b0000, got, cycles, t1);
                if (got !== exp) begin
                    $display("Fail at %0t: data_rdata_o got %h expected %h", $time, got, exp);
                    errors++;
                end
                if (hit && cycles != 1) begin
                    $display("read hit at %h took %0d cycles instead of one", addr, cycles);
                    errors++;
                end
            end
        end
        end_test("cached reads and writes", err0);

        // data side first, then the same proof on the fetch side.
        err0 = errors;
        addr = 32'h4004_0100;
        model_dc_read(addr, exp, hit);
        data_access(addr, '0, 4'b0000, got, cycles, t1);
        backdoor_write(addr, ~got);
        model_dc_read(addr, exp, hit);
        data_access(addr, '0, 4'b0000, got, cycles, t1);
        if (got !== exp) begin
            $display("Fail at %0t: data_rdata_o got %h expected %h", $time, got, exp);
            errors++;
        end
        data_access((addr & 32'h0007_ffff) | 32'h2000_0000, '0, 4'b0000, got, cycles, t1);
        if (got !== ref_mem[addr[18:2]]) begin
            $display("Fail at %0t: data_rdata_o got %h expected %h", $time, got,
                     ref_mem[addr[18:2]]);
            errors++;
        end
        addr = 32'h0000_0800;
        model_ic_fetch(addr, exp, hit);
        fetch(addr, got, cycles);
        backdoor_write(addr, ~got);
        model_ic_fetch(addr, exp, hit);
        fetch(addr, got, cycles);
        if (got !== exp) begin
            $display("Fail at %0t: ifetch_data_o got %h expected %h", $time, got, exp);
            errors++;
        end
        data_access(addr | 32'h2000_0000, '0, 4'b0000, got, cycles, t1);
        if (got !== ref_mem[addr[18:2]]) begin
            $display("Fail at %0t: data_rdata_o got %h expected %h", $time, got,
                     ref_mem[addr[18:2]]);
            errors++;
        end
        end_test("cache hit proof", err0);

        err0 = errors;
        addr = 32'h4006_0000 | (($urandom % 16) << 2);
        wdata = $urandom;
        model_dc_write(addr, wdata, 4'b1111);
        data_access(addr, wdata, 4'b1111, got, cycles, t1);
        backdoor_write(addr, $urandom);
        model_dc_read(addr, exp, hit);
        data_access(addr, '0, 4'b0000, got, cycles, t1);
        if (got !== exp) begin
            $display("Fail at %0t: data_rdata_o got %h expected %h", $time, got, exp);
            errors++;
        end
        end_test("write miss no allocate", err0);

        err0 = errors;
        data_access(32'h1000_0000, '0, 4'b0000, first, cycles, t1);
        exp = 32'((t1 - last_low_t) / PERIOD - 1);  // edges after the last reset edge.
        if (first !== exp) begin
            $display("Fail at %0t: timer count got %h expected %h", $time, first, exp);
            errors++;
        end
        k = 3 + int'($urandom % 20);
        repeat (k) @(negedge clk_i);
        data_access(32'h1000_0000, '0, 4'b0000, got, cycles, t2);
        if (got - first !== 32'((t2 - t1) / PERIOD)) begin
            $display("Fail at %0t: timer delta got %h expected %h", $time, got - first,
                     32'((t2 - t1) / PERIOD));
            errors++;
        end
        if (cycles != 1) begin
            $display("timer read stalled for %0d cycles", cycles);
            errors++;
        end
        end_test("cycle timer", err0);

        // fetch miss and data miss in the same cycle, slow memory.
        err0 = errors;
        min_dly = 6;
        max_dly = 12;
        addr  = 32'h0000_f000 | (($urandom % 16) << 2);
        daddr = 32'h4006_1000 | (($urandom % 16) << 2);
        model_ic_fetch(addr, exp_i, hit);
        model_dc_read(daddr, exp, hit);
        log_base = xfer_log.size();
        @(negedge clk_i);
        ifetch_addr_i    = addr;
        data_req_i.sel   = 1'b1;
        data_req_i.addr  = daddr;
        data_req_i.wstrb = 4'b0000;
        ic_done = 1'b0;
        dc_done = 1'b0;
        cycles  = 0;
        while (!(ic_done && dc_done) && cycles < TIMEOUT) begin
            @(posedge clk_i);
            cycles++;
            if (!dc_done && !data_stall_o) begin
                dc_done = 1'b1;
                got     = data_rdata_o;
            end
            if (!ic_done && !ifetch_stall_o) begin
                ic_done = 1'b1;
                got_i   = ifetch_data_o;
            end
        end
        @(negedge clk_i);
        data_req_i.sel = 1'b0;
        if (!(ic_done && dc_done)) begin
            $display("concurrent misses not finished after %0d cycles", TIMEOUT);
            errors++;
        end
        if (got !== exp) begin
            $display("Fail at %0t: data_rdata_o got %h expected %h", $time, got, exp);
            errors++;
        end
        if (got_i !== exp_i) begin
            $display("Fail at %0t: ifetch_data_o got %h expected %h", $time, got_i, exp_i);
            errors++;
        end
        if (xfer_log.size() != log_base + 2) begin
            $display("expected two memory transfers, saw %0d", xfer_log.size() - log_base);
            errors++;
        end else if (xfer_log[log_base] !== daddr[18:0] ||
                     xfer_log[log_base + 1] !== addr[18:0]) begin
            $display("memory transfers out of order, data request was not first");
            errors++;
        end
        min_dly = 0;
        max_dly = 4;
        end_test("arbitration priority", err0);

        $display("tests run 6, tests with errors %0d, errors %0d", bad_tests, errors);
        if (errors == 0) begin
            $display("Testbench passed");
        end else begin
            $display("Testbench failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* mem_subsys_top.f */
mem_subsys_pkg.sv
cycle_timer.sv
icache.sv
dcache.sv
data_router.sv
mem_arbiter.sv
mem_subsys_top.sv
tb_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
# build the memory subsystem testbench with Verilator, run it, and check the log
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module tb_mem_subsys -f mem_subsys_top.f -o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -qx "Testbench passed" sim.log; then
    echo "simulation ok"
    exit 0
fi
echo "simulation reported failure"
exit 1
